// ==== hdl/oramPkg.sv ====
// Path ORAM shared definitions
// Tree geometry, command codes and the block record

package oramPkg;

	//----------------------------------------
	// Tree geometry
	//----------------------------------------
	localparam int treeLevels      = 4;
	localparam int leafWidth       = 3;
	localparam int slotsPerBucket  = 2;
	localparam int bucketAddrWidth = 4;

	// One path of 8 slots plus room for overflow
	localparam int stashDepth      = 16;

	//----------------------------------------
	// Client data
	//----------------------------------------
	localparam int addrWidth       = 4;
	localparam int dataWidth       = 32;

	typedef enum logic {
		cmdRead  = 1'b0,
		cmdWrite = 1'b1
	} cmdT;

	typedef enum logic {
		memRead  = 1'b0,
		memWrite = 1'b1
	} memCmdT;

	// Valid flag clear marks a dummy slot
	typedef struct packed {
		logic                 valid;
		logic [addrWidth-1:0] pAddr;
		logic [leafWidth-1:0] leaf;
		logic [dataWidth-1:0] data;
	} blockT;

endpackage

// ==== hdl/stashIf.sv ====
// Controller to stash bundle
// Insert, lookup/update and eviction signals

`timescale 1ns/10ps

interface stashIf #(
	parameter int treeLevels = oramPkg::treeLevels
);
	localparam int levelWidth = $clog2(treeLevels);

	// Blocks arriving from a path read
	logic                              insertValid;
	oramPkg::blockT                    insertBlock;

	// Lookup and update of the requested block
	logic [oramPkg::addrWidth-1:0]     lookupAddr;
	logic                              lookupHit;
	logic [oramPkg::dataWidth-1:0]     lookupData;
	logic                              updateEn;
	logic [oramPkg::dataWidth-1:0]     updateData;
	logic [oramPkg::leafWidth-1:0]     updateLeaf;

	// Eviction choice for the bucket being written back
	logic [oramPkg::leafWidth-1:0]     evictLeaf;
	logic [levelWidth-1:0]             evictLevel;
	logic                              evictTake;
	oramPkg::blockT                    evictBlock;

	modport controller (
		output insertValid, insertBlock, lookupAddr, updateEn, updateData, updateLeaf,
		output evictLeaf, evictLevel, evictTake,
		input  lookupHit, lookupData, evictBlock
	);

	modport stash (
		input  insertValid, insertBlock, lookupAddr, updateEn, updateData, updateLeaf,
		input  evictLeaf, evictLevel, evictTake,
		output lookupHit, lookupData, evictBlock
	);

endinterface

// ==== hdl/positionMap.sv ====
// Position map
// One leaf per program address, remapped to a random leaf on every access

`timescale 1ns/10ps

module positionMap (
	input  logic                          clock,
	input  logic                          rstN,
	input  logic [oramPkg::addrWidth-1:0] addr,
	input  logic                          remap,
	output logic [oramPkg::leafWidth-1:0] oldLeaf,
	output logic [oramPkg::leafWidth-1:0] newLeaf
);

	localparam int numAddrs = 1 << oramPkg::addrWidth;

	logic [oramPkg::leafWidth-1:0] leafTable [numAddrs];
	logic [7:0]                    lfsr;
	logic                          feedback;

	// x^8 + x^6 + x^5 + x^4 + 1
	assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	//----------------------------------------
	// Random source, free running
	//----------------------------------------
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			lfsr <= 8'hA5;
		end else begin
			lfsr <= {lfsr[6:0], feedback};
		end
	end

	//----------------------------------------
	// Leaf table
	//----------------------------------------
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numAddrs; i++) begin
				leafTable[i] <= '0;
			end
			newLeaf <= '0;
		end else if (remap) begin
			leafTable[addr] <= lfsr[oramPkg::leafWidth-1:0];
			newLeaf         <= lfsr[oramPkg::leafWidth-1:0];
		end
	end

	// Current leaf, read before the remap edge
	assign oldLeaf = leafTable[addr];

endmodule

// ==== hdl/stash.sv ====
// Stash
// Holds blocks of the current path, serves lookups and picks blocks for eviction

`timescale 1ns/10ps

module stash #(
	parameter int treeLevels = oramPkg::treeLevels,
	parameter int stashDepth = oramPkg::stashDepth
) (
	input logic  clock,
	input logic  rstN,
	stashIf.stash bus
);

	localparam int idxWidth = $clog2(stashDepth);

	oramPkg::blockT        entries [stashDepth];
	logic [stashDepth-1:0] used;

	logic                  freeFound;
	logic [idxWidth-1:0]   freeIdx;
	logic                  hitFound;
	logic [idxWidth-1:0]   hitIdx;
	logic                  evictFound;
	logic [idxWidth-1:0]   evictIdx;
	logic                  insertNow;
	logic                  dupFound;

	//----------------------------------------
	// Combinational search
	//----------------------------------------
	always_comb begin
		int shiftAmt;
		shiftAmt   = treeLevels - 1 - int'(bus.evictLevel);
		freeFound  = 1'b0;
		freeIdx    = '0;
		hitFound   = 1'b0;
		hitIdx     = '0;
		evictFound = 1'b0;
		evictIdx   = '0;
		for (int i = 0; i < stashDepth; i++) begin
			if (!freeFound && !used[i]) begin
				freeFound = 1'b1;
				freeIdx   = idxWidth'(i);
			end
			if (!hitFound && used[i] && entries[i].pAddr == bus.lookupAddr) begin
				hitFound = 1'b1;
				hitIdx   = idxWidth'(i);
			end
			// Leaves agree on every branch above this level
			if (!evictFound && used[i] &&
					((entries[i].leaf ^ bus.evictLeaf) >> shiftAmt) == '0) begin
				evictFound = 1'b1;
				evictIdx   = idxWidth'(i);
			end
		end
	end

	assign bus.lookupHit  = hitFound;
	assign bus.lookupData = hitFound ? entries[hitIdx].data : '0;
	assign bus.evictBlock = evictFound ? entries[evictIdx] : '0;

	// Dummies from memory are dropped here
	assign insertNow = bus.insertValid && bus.insertBlock.valid && freeFound;

	//----------------------------------------
	// Occupancy
	//----------------------------------------
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			used <= '0;
		end else begin
			if (insertNow || (bus.updateEn && !hitFound && freeFound)) begin
				used[freeIdx] <= 1'b1;
			end
			if (bus.evictTake && evictFound) begin
				used[evictIdx] <= 1'b0;
			end
		end
	end

	// Block contents
	always_ff @(posedge clock) begin
		if (insertNow) begin
			entries[freeIdx] <= bus.insertBlock;
		end
		if (bus.updateEn) begin
			if (hitFound) begin
				entries[hitIdx].data <= bus.updateData;
				entries[hitIdx].leaf <= bus.updateLeaf;
			end else begin
				// First touch of this address
				entries[freeIdx] <= '{valid: 1'b1, pAddr: bus.lookupAddr,
					leaf: bus.updateLeaf, data: bus.updateData};
			end
		end
	end

	//----------------------------------------
	// Checks
	//----------------------------------------
	always_comb begin
		dupFound = 1'b0;
		for (int i = 0; i < stashDepth; i++) begin
			for (int j = i + 1; j < stashDepth; j++) begin
				if (used[i] && used[j] && entries[i].pAddr == entries[j].pAddr) begin
					dupFound = 1'b1;
				end
			end
		end
	end

	insertRoom: assert property (@(posedge clock) disable iff (!rstN)
		bus.insertValid && bus.insertBlock.valid |-> !(&used))
		else $error("stash insert with all entries full");

	uniqueAddr: assert property (@(posedge clock) disable iff (!rstN) !dupFound)
		else $error("stash holds one address twice");

endmodule

// ==== hdl/levelCounter.sv ====
// Path walk counter
// Steps through bucket slots level by level, root first or leaf first

`timescale 1ns/10ps

module levelCounter #(
	parameter int  treeLevels     = oramPkg::treeLevels,
	parameter int  slotsPerBucket = oramPkg::slotsPerBucket,
	localparam int levelWidth     = $clog2(treeLevels),
	localparam int slotWidth      = (slotsPerBucket > 1) ? $clog2(slotsPerBucket) : 1
) (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic                  start,
	input  logic                  down,
	input  logic                  step,
	output logic [levelWidth-1:0] level,
	output logic [slotWidth-1:0]  slot,
	output logic                  last
);

	logic                  goingDown;
	logic                  done;
	logic                  slotWrap;
	logic [levelWidth-1:0] endLevel;

	assign slotWrap = slot == slotWidth'(slotsPerBucket - 1);
	assign endLevel = goingDown ? '0 : levelWidth'(treeLevels - 1);
	assign last     = slotWrap && (level == endLevel);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			level     <= '0;
			slot      <= '0;
			goingDown <= 1'b0;
			done      <= 1'b0;
		end else if (start) begin
			level     <= down ? levelWidth'(treeLevels - 1) : '0;
			slot      <= '0;
			goingDown <= down;
			done      <= 1'b0;
		end else if (step) begin
			done <= last;
			if (slotWrap) begin
				slot  <= '0;
				level <= goingDown ? level - 1'b1 : level + 1'b1;
			end else begin
				slot <= slot + 1'b1;
			end
		end
	end

	noStepPastEnd: assert property (@(posedge clock) disable iff (!rstN)
		step && !start |-> !done)
		else $error("level counter stepped past the end of the path");

endmodule

// ==== hdl/accessFsm.sv ====
// Access controller
// Sequences remap, path read, serve and path writeback for one ORAM access

`timescale 1ns/10ps

module accessFsm #(
	parameter int  treeLevels     = oramPkg::treeLevels,
	parameter int  slotsPerBucket = oramPkg::slotsPerBucket,
	localparam int levelWidth     = $clog2(treeLevels),
	localparam int slotWidth      = (slotsPerBucket > 1) ? $clog2(slotsPerBucket) : 1
) (
	input  logic                                clock,
	input  logic                                rstN,
	input  oramPkg::cmdT                        cmd,
	input  logic [oramPkg::addrWidth-1:0]       pAddr,
	input  logic [oramPkg::dataWidth-1:0]       dataIn,
	input  logic                                cmdValid,
	output logic                                cmdReady,
	output logic [oramPkg::dataWidth-1:0]       dataOut,
	output logic                                dataOutValid,
	input  logic                                dataOutReady,
	output logic [oramPkg::bucketAddrWidth-1:0] memAddress,
	output oramPkg::memCmdT                     memCommand,
	output logic                                memCommandValid,
	input  logic                                memCommandReady,
	input  oramPkg::blockT                      memReadData,
	input  logic                                memReadDataValid,
	output oramPkg::blockT                      memWriteData,
	output logic                                memWriteDataValid,
	input  logic                                memWriteDataReady,
	output logic [oramPkg::addrWidth-1:0]       mapAddr,
	output logic                                remap,
	input  logic [oramPkg::leafWidth-1:0]       oldLeaf,
	input  logic [oramPkg::leafWidth-1:0]       newLeaf,
	output logic                                cntStart,
	output logic                                cntDown,
	output logic                                cntStep,
	input  logic [levelWidth-1:0]               level,
	input  logic [slotWidth-1:0]                slot,
	input  logic                                last,
	stashIf.controller                          bus
);

	typedef logic [oramPkg::bucketAddrWidth-1:0] bucketT;

	typedef enum logic [2:0] {
		stIdle, stRemap, stReadCmd, stReadData, stServe, stWriteCmd, stWriteData, stRespond
	} stateT;

	stateT                         state, nextState;
	oramPkg::cmdT                  reqCmd;
	logic [oramPkg::addrWidth-1:0] reqAddr;
	logic [oramPkg::dataWidth-1:0] reqData;
	logic [oramPkg::dataWidth-1:0] respData;
	logic [oramPkg::dataWidth-1:0] servedData;
	logic [oramPkg::leafWidth-1:0] pathLeaf;
	logic                          bucketDone;

	// Heap index of the bucket at this level on the path to leaf
	function automatic bucketT bucketOf(input logic [oramPkg::leafWidth-1:0] leaf,
			input logic [levelWidth-1:0] lvl);
		int shiftAmt;
		shiftAmt = treeLevels - 1 - int'(lvl);
		return bucketT'((1 << lvl) - 1 + (leaf >> shiftAmt));
	endfunction

	//----------------------------------------
	// State sequencing
	//----------------------------------------
	assign bucketDone = slot == slotWidth'(slotsPerBucket - 1);

	always_comb begin
		nextState = state;
		case (state)
			stIdle:      if (cmdValid) nextState = stRemap;
			stRemap:     nextState = stReadCmd;
			stReadCmd:   if (memCommandReady) nextState = stReadData;
			stReadData:
				if (memReadDataValid && bucketDone) begin
					nextState = last ? stServe : stReadCmd;
				end
			stServe:     nextState = stWriteCmd;
			stWriteCmd:  if (memCommandReady) nextState = stWriteData;
			stWriteData:
				if (memWriteDataReady && bucketDone) begin
					if (!last) begin
						nextState = stWriteCmd;
					end else begin
						nextState = (reqCmd == oramPkg::cmdRead) ? stRespond : stIdle;
					end
				end
			stRespond:   if (dataOutReady) nextState = stIdle;
			default:     nextState = stIdle;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	// Request and path captured once per access
	always_ff @(posedge clock) begin
		if (state == stIdle && cmdValid) begin
			reqCmd  <= cmd;
			reqAddr <= pAddr;
			reqData <= dataIn;
		end
		if (state == stRemap) begin
			pathLeaf <= oldLeaf;
		end
		if (state == stServe) begin
			respData <= servedData;
		end
	end

	//----------------------------------------
	// Outputs
	//----------------------------------------
	assign cmdReady     = state == stIdle;
	assign dataOut      = respData;
	assign dataOutValid = state == stRespond;

	assign mapAddr  = reqAddr;
	assign remap    = state == stRemap;
	assign cntStart = (state == stRemap) || (state == stServe);
	assign cntDown  = state == stServe;
	assign cntStep  = (state == stReadData && memReadDataValid) ||
		(state == stWriteData && memWriteDataReady);

	assign memAddress      = bucketOf(pathLeaf, level);
	assign memCommandValid = (state == stReadCmd) || (state == stWriteCmd);
	assign memCommand      = (state == stWriteCmd) ? oramPkg::memWrite : oramPkg::memRead;

	// Eviction choice stays put until the beat is taken
	assign memWriteData      = bus.evictBlock;
	assign memWriteDataValid = state == stWriteData;

	assign bus.insertValid = (state == stReadData) && memReadDataValid;
	assign bus.insertBlock = memReadData;
	assign bus.lookupAddr  = reqAddr;
	assign servedData      = bus.lookupHit ? bus.lookupData : '0;
	assign bus.updateEn    = state == stServe;
	assign bus.updateData  = (reqCmd == oramPkg::cmdWrite) ? reqData : servedData;
	assign bus.updateLeaf  = newLeaf;
	assign bus.evictLeaf   = pathLeaf;
	assign bus.evictLevel  = level;
	assign bus.evictTake   = (state == stWriteData) && memWriteDataReady;

	memCmdHeld: assert property (@(posedge clock) disable iff (!rstN)
		memCommandValid && !memCommandReady |=>
			memCommandValid && $stable(memCommand) && $stable(memAddress))
		else $error("memory command changed while stalled");

endmodule

// ==== hdl/pathOramTop.sv ====
// Path ORAM top level
// Client command/response ports on one side, bucket memory ports on the other

`timescale 1ns/10ps

module pathOramTop #(
	parameter int  treeLevels     = oramPkg::treeLevels,
	parameter int  slotsPerBucket = oramPkg::slotsPerBucket,
	parameter int  stashDepth     = oramPkg::stashDepth,
	localparam int levelWidth     = $clog2(treeLevels),
	localparam int slotWidth      = (slotsPerBucket > 1) ? $clog2(slotsPerBucket) : 1
) (
	input  logic                                clock,
	input  logic                                rstN,

	input  oramPkg::cmdT                        cmd,
	input  logic [oramPkg::addrWidth-1:0]       pAddr,
	input  logic [oramPkg::dataWidth-1:0]       dataIn,
	input  logic                                cmdValid,
	output logic                                cmdReady,
	output logic [oramPkg::dataWidth-1:0]       dataOut,
	output logic                                dataOutValid,
	input  logic                                dataOutReady,

	output logic [oramPkg::bucketAddrWidth-1:0] memAddress,
	output oramPkg::memCmdT                     memCommand,
	output logic                                memCommandValid,
	input  logic                                memCommandReady,
	input  oramPkg::blockT                      memReadData,
	input  logic                                memReadDataValid,
	output oramPkg::blockT                      memWriteData,
	output logic                                memWriteDataValid,
	input  logic                                memWriteDataReady
);

	logic [oramPkg::addrWidth-1:0] mapAddr;
	logic                          remap;
	logic [oramPkg::leafWidth-1:0] oldLeaf, newLeaf;
	logic                          cntStart, cntDown, cntStep, last;
	logic [levelWidth-1:0]         level;
	logic [slotWidth-1:0]          slot;

	stashIf #(.treeLevels(treeLevels)) stashBus ();

	//----------------------------------------
	// Core blocks
	//----------------------------------------
	positionMap posMap (
		.clock(clock), .rstN(rstN),
		.addr(mapAddr), .remap(remap), .oldLeaf(oldLeaf), .newLeaf(newLeaf)
	);

	stash #(.treeLevels(treeLevels), .stashDepth(stashDepth)) blockStash (
		.clock(clock), .rstN(rstN), .bus(stashBus.stash)
	);

	levelCounter #(.treeLevels(treeLevels), .slotsPerBucket(slotsPerBucket)) levelCnt (
		.clock(clock), .rstN(rstN),
		.start(cntStart), .down(cntDown), .step(cntStep),
		.level(level), .slot(slot), .last(last)
	);

	accessFsm #(.treeLevels(treeLevels), .slotsPerBucket(slotsPerBucket)) ctrl (
		.clock(clock), .rstN(rstN),
		.cmd(cmd), .pAddr(pAddr), .dataIn(dataIn), .cmdValid(cmdValid), .cmdReady(cmdReady),
		.dataOut(dataOut), .dataOutValid(dataOutValid), .dataOutReady(dataOutReady),
		.memAddress(memAddress), .memCommand(memCommand),
		.memCommandValid(memCommandValid), .memCommandReady(memCommandReady),
		.memReadData(memReadData), .memReadDataValid(memReadDataValid),
		.memWriteData(memWriteData), .memWriteDataValid(memWriteDataValid),
		.memWriteDataReady(memWriteDataReady),
		.mapAddr(mapAddr), .remap(remap), .oldLeaf(oldLeaf), .newLeaf(newLeaf),
		.cntStart(cntStart), .cntDown(cntDown), .cntStep(cntStep),
		.level(level), .slot(slot), .last(last),
		.bus(stashBus.controller)
	);

endmodule

// ==== tb/memModel.sv ====
// Bucket memory model
// Serves bucket reads and writes with random stalls and checks path addressing

`timescale 1ns/10ps

module memModel (
	input  logic                                clock,
	input  logic                                rstN,
	input  logic [oramPkg::bucketAddrWidth-1:0] memAddress,
	input  oramPkg::memCmdT                     memCommand,
	input  logic                                memCommandValid,
	output logic                                memCommandReady,
	output oramPkg::blockT                      memReadData,
	output logic                                memReadDataValid,
	input  oramPkg::blockT                      memWriteData,
	input  logic                                memWriteDataValid,
	output logic                                memWriteDataReady,
	output int                                  cmdsSeen,
	output int                                  errCount
);

	localparam int numBuckets    = (1 << oramPkg::treeLevels) - 1;
	localparam int slots         = oramPkg::slotsPerBucket;
	localparam int cmdsPerAccess = 2 * oramPkg::treeLevels;

	typedef enum {modeIdle, modeRead, modeWrite} modeT;

	oramPkg::blockT mem [numBuckets * slots];
	int             pathAddr [oramPkg::treeLevels];
	modeT           mode;
	int             beat;
	int             curBucket;
	int             curLevel;
	integer         seed = 22;

	// Outputs sit low until the first clock
	logic           cmdReadyR   = 1'b0;
	logic           readValidR  = 1'b0;
	logic           writeReadyR = 1'b0;
	oramPkg::blockT readDataR   = '0;

	assign memCommandReady   = cmdReadyR;
	assign memReadData       = readDataR;
	assign memReadDataValid  = readValidR;
	assign memWriteDataReady = writeReadyR;

	// Ready or valid in about three cycles out of four
	function automatic bit stallFree();
		return ({$random(seed)} % 4) != 0;
	endfunction

	//----------------------------------------
	// Path checks
	//----------------------------------------
	task automatic checkCommand();
		int   idx;
		int   expAddr;
		logic isWrite;
		idx      = cmdsSeen % cmdsPerAccess;
		isWrite  = idx >= oramPkg::treeLevels;
		curLevel = isWrite ? cmdsPerAccess - 1 - idx : idx;
		assert (memCommand == (isWrite ? oramPkg::memWrite : oramPkg::memRead)) else begin
			errCount++;
			$display("** Error at %0t: memCommand = %0d, expected %0d",
				$time, memCommand, isWrite);
		end
		if (isWrite) begin
			expAddr = pathAddr[curLevel];
		end else if (curLevel == 0) begin
			expAddr = 0;
		end else begin
			// Either child of the bucket one level up
			expAddr = 2 * pathAddr[curLevel - 1] + 1;
			if (int'(memAddress) == expAddr + 1) begin
				expAddr++;
			end
		end
		assert (int'(memAddress) == expAddr) else begin
			errCount++;
			$display("** Error at %0t: memAddress = %0d, expected %0d",
				$time, memAddress, expAddr);
		end
		if (!isWrite) begin
			pathAddr[curLevel] = memAddress;
		end
		cmdsSeen++;
	endtask

	task automatic storeBeat();
		oramPkg::blockT blk;
		int             expBucket;
		blk = memWriteData;
		mem[curBucket * slots + beat] = blk;
		if (blk.valid) begin
			// A real block may only sit on the path to its own leaf
			expBucket = (1 << curLevel) - 1 +
				(int'(blk.leaf) >> (oramPkg::treeLevels - 1 - curLevel));
			assert (curBucket == expBucket) else begin
				errCount++;
				$display("** Error at %0t: memAddress = %0d for leaf %0d, expected %0d",
					$time, curBucket, blk.leaf, expBucket);
			end
		end
	endtask

	//----------------------------------------
	// Command and data channels
	//----------------------------------------
	always @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numBuckets * slots; i++) begin
				mem[i] = '0;
			end
			mode = modeIdle;
			beat = 0;
			cmdReadyR   <= 1'b0;
			readValidR  <= 1'b0;
			writeReadyR <= 1'b0;
		end else begin
			readValidR <= 1'b0;
			case (mode)
				modeIdle: begin
					if (memCommandValid && cmdReadyR) begin
						checkCommand();
						curBucket = memAddress;
						beat      = 0;
						cmdReadyR <= 1'b0;
						mode = (memCommand == oramPkg::memWrite) ? modeWrite : modeRead;
					end else begin
						cmdReadyR <= stallFree();
					end
				end
				modeRead: begin
					if (stallFree()) begin
						readValidR <= 1'b1;
						readDataR  <= mem[curBucket * slots + beat];
						beat++;
						if (beat == slots) begin
							mode = modeIdle;
						end
					end
				end
				modeWrite: begin
					if (memWriteDataValid && writeReadyR) begin
						storeBeat();
						beat++;
					end
					if (beat == slots) begin
						writeReadyR <= 1'b0;
						mode = modeIdle;
					end else begin
						writeReadyR <= stallFree();
					end
				end
				default: mode = modeIdle;
			endcase
		end
	end

endmodule

// ==== tb/pathOramTb.sv ====
// Path ORAM testbench
// Table of client accesses checked against a shadow copy of the address space

`timescale 1ns/10ps

module pathOramTb;

	localparam int clockPeriod = 4;
	localparam int resetCycles = 4;
	localparam int numAddrs    = 1 << oramPkg::addrWidth;
	localparam int numFixed    = 14;
	localparam int numRandom   = 34;
	localparam int numEntries  = numFixed + numAddrs + numRandom;
	// Generous bound on one access under memory and response stalls
	localparam int worstAccessCycles = 300;
	localparam int watchdogTime = (numEntries * worstAccessCycles + 20) * clockPeriod;

	typedef struct packed {
		oramPkg::cmdT                  cmd;
		logic [oramPkg::addrWidth-1:0] addr;
		logic [oramPkg::dataWidth-1:0] data;
	} entryT;

	logic                                clock;
	logic                                rstN;
	oramPkg::cmdT                        cmd;
	logic [oramPkg::addrWidth-1:0]       pAddr;
	logic [oramPkg::dataWidth-1:0]       dataIn;
	logic                                cmdValid;
	logic                                cmdReady;
	logic [oramPkg::dataWidth-1:0]       dataOut;
	logic                                dataOutValid;
	logic                                dataOutReady;
	logic [oramPkg::bucketAddrWidth-1:0] memAddress;
	oramPkg::memCmdT                     memCommand;
	logic                                memCommandValid;
	logic                                memCommandReady;
	oramPkg::blockT                      memReadData;
	logic                                memReadDataValid;
	oramPkg::blockT                      memWriteData;
	logic                                memWriteDataValid;
	logic                                memWriteDataReady;
	int                                  memCmds;
	int                                  memErrors;

	entryT                         stimTable[$];
	logic [oramPkg::dataWidth-1:0] shadow [numAddrs];
	integer                        seed = 22;
	int                            errors;
	int                            readsIssued;
	int                            responsesSeen;
	bit                            validBefore;
	bit                            timedOut;

	pathOramTop #(
		.treeLevels(oramPkg::treeLevels),
		.slotsPerBucket(oramPkg::slotsPerBucket),
		.stashDepth(oramPkg::stashDepth)
	) uut (
		.clock(clock), .rstN(rstN),
		.cmd(cmd), .pAddr(pAddr), .dataIn(dataIn), .cmdValid(cmdValid), .cmdReady(cmdReady),
		.dataOut(dataOut), .dataOutValid(dataOutValid), .dataOutReady(dataOutReady),
		.memAddress(memAddress), .memCommand(memCommand),
		.memCommandValid(memCommandValid), .memCommandReady(memCommandReady),
		.memReadData(memReadData), .memReadDataValid(memReadDataValid),
		.memWriteData(memWriteData), .memWriteDataValid(memWriteDataValid),
		.memWriteDataReady(memWriteDataReady)
	);

	memModel bucketMem (
		.clock(clock), .rstN(rstN),
		.memAddress(memAddress), .memCommand(memCommand),
		.memCommandValid(memCommandValid), .memCommandReady(memCommandReady),
		.memReadData(memReadData), .memReadDataValid(memReadDataValid),
		.memWriteData(memWriteData), .memWriteDataValid(memWriteDataValid),
		.memWriteDataReady(memWriteDataReady),
		.cmdsSeen(memCmds), .errCount(memErrors)
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	// Each response counted once, on the cycle it first shows
	always @(negedge clock) begin
		if (rstN && dataOutValid && !validBefore) begin
			responsesSeen++;
		end
		validBefore = dataOutValid;
	end

	//----------------------------------------
	// Helpers
	//----------------------------------------
	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic addEntry(input oramPkg::cmdT c, input int a, input logic [31:0] d);
		entryT e;
		e.cmd  = c;
		e.addr = a[oramPkg::addrWidth-1:0];
		e.data = d;
		stimTable.push_back(e);
	endtask

	task automatic buildTable();
		addEntry(oramPkg::cmdRead, 3, '0);
		addEntry(oramPkg::cmdWrite, 3, 32'hDEADBEEF);
		addEntry(oramPkg::cmdRead, 3, '0);
		addEntry(oramPkg::cmdRead, 3, '0);
		addEntry(oramPkg::cmdRead, 5, '0);
		addEntry(oramPkg::cmdWrite, 5, 32'h12345678);
		addEntry(oramPkg::cmdRead, 3, '0);
		addEntry(oramPkg::cmdRead, 5, '0);
		addEntry(oramPkg::cmdWrite, 3, 32'hCAFEF00D);
		addEntry(oramPkg::cmdRead, 3, '0);
		addEntry(oramPkg::cmdWrite, 0, 32'hA5A5A5A5);
		addEntry(oramPkg::cmdWrite, 15, 32'h0F0F0F0F);
		addEntry(oramPkg::cmdRead, 0, '0);
		addEntry(oramPkg::cmdRead, 15, '0);
		// Sweep of writes, then a mixed run
		for (int a = 0; a < numAddrs; a++) begin
			addEntry(oramPkg::cmdWrite, a, $random(seed));
		end
		for (int k = 0; k < numRandom; k++) begin
			addEntry(({$random(seed)} % 2) ? oramPkg::cmdWrite : oramPkg::cmdRead,
				{$random(seed)} % numAddrs, $random(seed));
		end
	endtask

	task automatic runAccess(input entryT e, input int accessNum);
		int stall;
		@(posedge clock);
		cmdValid <= 1'b1;
		cmd      <= e.cmd;
		pAddr    <= e.addr;
		dataIn   <= e.data;
		do @(negedge clock); while (!cmdReady);
		@(posedge clock);
		cmdValid <= 1'b0;
		if (e.cmd == oramPkg::cmdWrite) begin
			shadow[e.addr] = e.data;
			do @(negedge clock); while (!cmdReady);
		end else begin
			readsIssued++;
			do begin
				@(negedge clock);
				checkValue("cmdReady", cmdReady, 0);
			end while (!dataOutValid);
			checkValue("dataOut", dataOut, shadow[e.addr]);
			stall = {$random(seed)} % 6;
			// Response held off, then taken
			repeat (stall) begin
				@(negedge clock);
				checkValue("dataOutValid", dataOutValid, 1);
				checkValue("dataOut", dataOut, shadow[e.addr]);
			end
			@(posedge clock);
			dataOutReady <= 1'b1;
			@(negedge clock);
			checkValue("dataOutValid", dataOutValid, 1);
			checkValue("dataOut", dataOut, shadow[e.addr]);
			@(posedge clock);
			dataOutReady <= 1'b0;
			@(negedge clock);
			checkValue("dataOutValid", dataOutValid, 0);
			checkValue("cmdReady", cmdReady, 1);
		end
		assert (memCmds == 2 * oramPkg::treeLevels * accessNum) else begin
			errors++;
			$display("Access %0d: memory saw %0d bucket commands in total, expected %0d",
				accessNum, memCmds, 2 * oramPkg::treeLevels * accessNum);
		end
		assert (responsesSeen == readsIssued) else begin
			errors++;
			$display("Access %0d: %0d read responses seen, expected %0d",
				accessNum, responsesSeen, readsIssued);
		end
	endtask

	task automatic finishRun();
		int total;
		total = errors + memErrors;
		$display("Error count: %0d in total, %0d in the testbench, %0d in the memory model",
			total, errors, memErrors);
		if (total == 0 && !timedOut) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	//----------------------------------------
	// Watchdog and main sequence
	//----------------------------------------
	initial begin
		#(watchdogTime);
		$display("Timeout: accesses still running after %0d ns", watchdogTime);
		timedOut = 1'b1;
		finishRun();
	end

	initial begin
		cmdValid     = 1'b0;
		cmd          = oramPkg::cmdRead;
		pAddr        = '0;
		dataIn       = '0;
		dataOutReady = 1'b0;
		rstN         = 1'b0;
		for (int i = 0; i < numAddrs; i++) begin
			shadow[i] = '0;
		end
		buildTable();
		repeat (resetCycles) @(posedge clock);
		rstN <= 1'b1;
		@(negedge clock);
		checkValue("cmdReady", cmdReady, 1);
		checkValue("dataOutValid", dataOutValid, 0);
		checkValue("memCommandValid", memCommandValid, 0);
		checkValue("memWriteDataValid", memWriteDataValid, 0);
		foreach (stimTable[i]) begin
			runAccess(stimTable[i], i + 1);
		end
		finishRun();
	end

endmodule

// ==== list.f ====
hdl/oramPkg.sv
hdl/stashIf.sv
hdl/positionMap.sv
hdl/stash.sv
hdl/levelCounter.sv
hdl/accessFsm.sv
hdl/pathOramTop.sv
tb/memModel.sv
tb/pathOramTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the Path ORAM testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
	--top-module pathOramTb -f list.f -o pathOramSim

./obj_dir/pathOramSim > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
